/* logsig_pkg.sv */
package logsig_pkg;

  // Sample format, signed Q4.4.
  localparam int SAMPLE_W    = 8;
  localparam int SAMPLE_FRAC = 4;

  // Lane counts on each side of the roller.
  localparam int LANES_IN  = 4;
  localparam int LANES_OUT = 2;

  // Output beats per input beat.
  localparam int ROLL_STEPS = LANES_IN / LANES_OUT;

  // Width of the roller step counter.
  localparam int STEP_W = (ROLL_STEPS > 1) ? $clog2(ROLL_STEPS) : 1;

  // Input beats the FIFO holds.
  localparam int FIFO_DEPTH = 4;

  // Number of entries in each lookup table.
  localparam int LUT_SIZE = 2 ** SAMPLE_W;

  // Saturation limits as integer codes.
  localparam int CODE_MIN = -(2 ** (SAMPLE_W - 1));
  localparam int CODE_MAX = (2 ** (SAMPLE_W - 1)) - 1;

  // One sample, read as signed Q4.4.
  typedef logic [SAMPLE_W-1:0] sample_t;

  // Roller step index.
  typedef logic [STEP_W-1:0] step_t;

  // Roller FSM.
  typedef enum logic {
    IDLE,
    SHIFT
  } roll_state_t;

endpackage

/* lane_fifo.sv */
`timescale 1ns/1ps

module lane_fifo
  import logsig_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic    clk,
  input  logic    arst_n,
  input  sample_t data_in [LANES_IN],
  input  logic    data_in_valid,
  output logic    data_in_ready,
  output sample_t data_out [LANES_IN],
  output logic    data_out_valid,
  input  logic    data_out_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  sample_t          mem [DEPTH][LANES_IN];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;     // Words held, output register included.
  logic [CNT_W-1:0] mem_words;
  logic             push;
  logic             pop;
  logic             load;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign data_in_ready = (count != CNT_W'(DEPTH));
  assign push          = data_in_valid && data_in_ready;
  assign pop           = data_out_valid && data_out_ready;
  assign mem_words     = count - CNT_W'(data_out_valid);

  // Refill the read word when it is empty or being taken.
  assign load = (mem_words != '0) && (!data_out_valid || pop);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      data_out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (load) begin
        rd_ptr         <= ptr_inc(rd_ptr);
        data_out_valid <= 1'b1;
      end else if (pop) begin
        data_out_valid <= 1'b0;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and read word.
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_in;
    end
    if (load) begin
      data_out <= mem[rd_ptr];
    end
  end

endmodule

/* lane_roller.sv */
`timescale 1ns/1ps

module lane_roller
  import logsig_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  sample_t data_in [LANES_IN],
  input  logic    data_in_valid,
  output logic    data_in_ready,
  output sample_t data_out [LANES_OUT],
  output logic    data_out_valid,
  input  logic    data_out_ready
);

  roll_state_t state;
  step_t       step;
  sample_t     shift_q [LANES_IN];
  logic        accept;
  logic        take;
  logic        last_step;

  assign last_step = (step == STEP_W'(ROLL_STEPS - 1));
  assign take      = data_out_valid && data_out_ready;

  // Take a new word while the last group leaves.
  assign data_in_ready  = (state == IDLE) || (last_step && data_out_ready);
  assign accept         = data_in_valid && data_in_ready;
  assign data_out_valid = (state == SHIFT);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      if (accept) begin
        state <= SHIFT;
        step  <= '0;
      end else if (take) begin
        if (last_step) begin
          state <= IDLE;
          step  <= '0;
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  // Load the wide word, then move the next group down.
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= data_in;
    end else if (take && !last_step) begin
      for (int i = 0; i < LANES_IN - LANES_OUT; i++) begin
        shift_q[i] <= shift_q[i + LANES_OUT];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < LANES_OUT; i++) begin
      data_out[i] = shift_q[i]; // Low lanes only.
    end
  end

endmodule

/* logsigmoid_lut.sv */
`timescale 1ns/1ps

module logsigmoid_lut
  import logsig_pkg::*;
(
  input  sample_t data_in,
  output sample_t data_out
);

  sample_t table_q [LUT_SIZE];

  // Rounded and saturated log-sigmoid of one raw code.
  function automatic sample_t logsig_code(input int code);
    int  signed_code;
    int  q;
    real x;
    real y;
    real scaled;
    if (code > CODE_MAX) begin
      signed_code = code - LUT_SIZE;
    end else begin
      signed_code = code;
    end
    x      = real'(signed_code) / real'(2 ** SAMPLE_FRAC);
    y      = -$ln(1.0 + $exp(-x));
    scaled = y * real'(2 ** SAMPLE_FRAC);
    // Halves go away from zero.
    if (scaled < 0.0) begin
      q = $rtoi(scaled - 0.5);
    end else begin
      q = $rtoi(scaled + 0.5);
    end
    if (q < CODE_MIN) begin
      q = CODE_MIN;
    end
    return sample_t'(q);
  endfunction

  // One elaboration constant per entry.
  for (genvar c = 0; c < LUT_SIZE; c++) begin : g_entry
    localparam sample_t ENTRY = logsig_code(c);
    assign table_q[c] = ENTRY;
  end

  assign data_out = table_q[data_in]; // Raw code is the index.

endmodule

/* logsigmoid_unit.sv */
`timescale 1ns/1ps

module logsigmoid_unit
  import logsig_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  sample_t data_in [LANES_IN],
  input  logic    data_in_valid,
  output logic    data_in_ready,
  output sample_t data_out [LANES_OUT],
  output logic    data_out_valid,
  input  logic    data_out_ready
);

  sample_t fifo_data [LANES_IN];
  logic    fifo_valid;
  logic    fifo_ready;

  sample_t roll_data [LANES_OUT];
  logic    roll_valid;

  // Whole input beats.
  lane_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (fifo_data),
    .data_out_valid (fifo_valid),
    .data_out_ready (fifo_ready)
  );

  // Wide beat to narrow beats.
  lane_roller i_roller (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (fifo_data),
    .data_in_valid  (fifo_valid),
    .data_in_ready  (fifo_ready),
    .data_out       (roll_data),
    .data_out_valid (roll_valid),
    .data_out_ready (data_out_ready)
  );

  for (genvar i = 0; i < LANES_OUT; i++) begin : g_lane
    logsigmoid_lut i_lut (
      .data_in  (roll_data[i]),
      .data_out (data_out[i])
    );
  end

  assign data_out_valid = roll_valid; // Tables add no delay.

endmodule

/* logsig_checker.sv */
`timescale 1ns/1ps

module logsig_checker
  import logsig_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  sample_t data_in [LANES_IN],
  input  logic    data_in_valid,
  input  logic    data_in_ready,
  input  sample_t data_out [LANES_OUT],
  input  logic    data_out_valid,
  input  logic    data_out_ready,
  output int      errors,
  output int      in_beats,
  output int      out_beats,
  output int      pending
);

  int exp_q [$]; // Expected codes in lane order.
  int src_q [$]; // Matching input codes.

  // -ln(1 + e^-x) on a Q4.4 code, magnitude rounded half up, then negated.
  function automatic int ref_logsig(input sample_t code);
    real x;
    real mag;
    int  q;
    x   = real'($signed(code)) / real'(2 ** SAMPLE_FRAC);
    mag = $ln(1.0 + $exp(-x)) * real'(2 ** SAMPLE_FRAC);
    q   = -$rtoi($floor(mag + 0.5));
    if (q < -(2 ** (SAMPLE_W - 1))) begin
      q = -(2 ** (SAMPLE_W - 1)); // Saturate at -8.0.
    end
    return q;
  endfunction

  always @(posedge clk or negedge arst_n) begin
    int exp_code;
    int src_code;
    int got_code;
    if (!arst_n) begin
      exp_q.delete();
      src_q.delete();
      errors    = 0;
      in_beats  = 0;
      out_beats = 0;
      pending   = 0;
    end else begin
      if (data_in_valid && data_in_ready) begin
        in_beats++;
        for (int l = 0; l < LANES_IN; l++) begin
          exp_q.push_back(ref_logsig(data_in[l]));
          src_q.push_back(int'($signed(data_in[l])));
        end
      end
      if (data_out_valid && data_out_ready) begin
        out_beats++;
        for (int l = 0; l < LANES_OUT; l++) begin
          got_code = int'($signed(data_out[l]));
          if (exp_q.size() == 0) begin
            $display("output beat at %0t carried lane %0d with no input sample behind it",
                     $time, l);
            errors++;
          end else begin
            exp_code = exp_q.pop_front();
            src_code = src_q.pop_front();
            if (got_code != exp_code) begin
              $display("error: %0t lane %0d input %0d expected %0d actual %0d",
                       $time, l, src_code, exp_code, got_code);
              errors++;
            end
          end
        end
      end
      pending = exp_q.size();
    end
  end

endmodule

/* tb_logsigmoid.sv */
`timescale 1ns/1ps

module tb_logsigmoid
  import logsig_pkg::*;
();

  localparam int WAIT_LIMIT = 200; // Cycles per wait.
  localparam int HOLD_LOW   = 20;
  localparam int RAND_BEATS = 120;

  logic        clk;
  logic        arst_n;
  sample_t     data_in [LANES_IN];
  logic        data_in_valid;
  logic        data_in_ready;
  sample_t     data_out [LANES_OUT];
  logic        data_out_valid;
  logic        data_out_ready;

  sample_t     stim [LANES_IN];
  int          ready_mode;  // 0 low, 1 high, 2 random.
  logic [31:0] rnd;
  logic [31:0] rnd_rdy;
  int          tb_errors;
  int          chk_errors;
  int          in_beats;
  int          out_beats;
  int          pending;
  int          accepted;
  int          low_run;
  int          guard;

  logsigmoid_unit i_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  logsig_checker i_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready),
    .errors         (chk_errors),
    .in_beats       (in_beats),
    .out_beats      (out_beats),
    .pending        (pending)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always #2 clk = ~clk;

  // Output back-pressure.
  always @(negedge clk) begin
    rnd_rdy = lcg_next(rnd_rdy);
    case (ready_mode)
      0:       data_out_ready = 1'b0;
      1:       data_out_ready = 1'b1;
      default: data_out_ready = rnd_rdy[20];
    endcase
  end

  task automatic check_reset_state(input string when);
    if (data_out_valid !== 1'b0 || data_in_ready !== 1'b1) begin
      $display("error: %0t %s data_out_valid=%b data_in_ready=%b",
               $time, when, data_out_valid, data_in_ready);
      tb_errors++;
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer.
  task automatic send_beat();
    int waited;
    waited        = 0;
    data_in       = stim;
    data_in_valid = 1'b1;
    while (!data_in_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!data_in_ready) begin
      $display("timeout at %0t waiting for data_in_ready to accept a beat", $time);
      tb_errors++;
    end
    @(negedge clk);
    data_in_valid = 1'b0;
  endtask

  task automatic random_stim();
    for (int l = 0; l < LANES_IN; l++) begin
      rnd     = lcg_next(rnd);
      stim[l] = rnd[23:16];
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((pending != 0 || data_out_valid) && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (pending != 0 || data_out_valid) begin
      $display("timeout at %0t waiting for the output to drain, %0d samples left",
               $time, pending);
      tb_errors++;
    end
  endtask

  initial begin
    clk           = 1'b0;
    arst_n        = 1'b0;
    data_in_valid = 1'b0;
    data_out_ready = 1'b1;
    ready_mode    = 1;
    rnd           = 32'h80d6;
    rnd_rdy       = lcg_next(32'h80d6);
    tb_errors     = 0;
    for (int l = 0; l < LANES_IN; l++) begin
      data_in[l] = '0;
      stim[l]    = '0;
    end

    for (int c = 0; c < 16; c++) begin
      @(negedge clk);
      check_reset_state("during reset");
    end
    arst_n = 1'b1;
    @(negedge clk);
    check_reset_state("after reset");

    // Every code once, four per beat.
    for (int b = 0; b < LUT_SIZE / LANES_IN; b++) begin
      for (int l = 0; l < LANES_IN; l++) begin
        stim[l] = sample_t'(b * LANES_IN + l);
      end
      send_beat();
    end
    wait_drain();

    ready_mode = 2;
    for (int n = 0; n < RAND_BEATS; n++) begin
      rnd = lcg_next(rnd);
      repeat (int'(rnd[17:16])) @(negedge clk); // Input gaps.
      random_stim();
      send_beat();
    end
    ready_mode = 1;
    wait_drain();

    // Fill with the output stalled.
    ready_mode = 0;
    @(negedge clk);
    accepted = 0;
    low_run  = 0;
    guard    = 0;
    while (low_run < HOLD_LOW && guard < WAIT_LIMIT) begin
      guard++;
      if (data_in_ready) begin
        random_stim();
        data_in       = stim;
        data_in_valid = 1'b1;
        @(negedge clk);
        data_in_valid = 1'b0;
        accepted++;
        low_run = 0;
      end else begin
        @(negedge clk);
        low_run++;
      end
    end
    if (low_run < HOLD_LOW) begin
      $display("timeout at %0t, data_in_ready never stayed low with the output stalled",
               $time);
      tb_errors++;
    end
    if (accepted != FIFO_DEPTH + 1) begin
      $display("error: %0t fill accepted %0d beats, expected %0d",
               $time, accepted, FIFO_DEPTH + 1);
      tb_errors++;
    end
    ready_mode = 1;
    wait_drain();

    if (pending != 0) begin
      $display("expected queue still holds %0d samples at the end", pending);
      tb_errors++;
    end
    if (out_beats != in_beats * ROLL_STEPS) begin
      $display("error: %0t %0d output beats for %0d input beats",
               $time, out_beats, in_beats);
      tb_errors++;
    end

    $display("errors %0d (checker %0d, testbench %0d), input beats %0d, output beats %0d",
             chk_errors + tb_errors, chk_errors, tb_errors, in_beats, out_beats);
    if (chk_errors + tb_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* flist.f */
logsig_pkg.sv
lane_fifo.sv
lane_roller.sv
logsigmoid_lut.sv
logsigmoid_unit.sv
logsig_checker.sv
tb_logsigmoid.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_logsigmoid
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
